// File: compile.f
+incdir+verification
source/cpuPkg.sv
source/fetchStage.sv
source/controlDecoder.sv
source/registerFile.sv
source/decodeStage.sv
source/hazardUnit.sv
source/executeStage.sv
source/memWriteback.sv
source/cpuCore.sv
verification/clockGen.sv
verification/cpuCoreTb.sv

// File: source/controlDecoder.sv
`timescale 1ns/1ps

module controlDecoder import cpuPkg::*; (
    input  instrWord   instr,
    output ctrlBundle  ctrl,
    output logic [1:0] aluOp,
    output logic       useRs,
    output logic       useRt
);

    always_comb begin
        ctrl = '0;
        aluOp = aluAdd;
        useRs = 1'b1;
        useRt = 1'b0;
        case (instr.rForm.opcode)
            opRtype: begin
                case (instr.rForm.func)
                    fnAdd, fnSub, fnAnd, fnOrr: begin
                        ctrl.regWrite = 1'b1;
                        aluOp = instr.rForm.func[1:0];
                        useRt = 1'b1;
                    end
                    // rs | 0 carries the value out
                    fnWwd: begin
                        ctrl.isWwd = 1'b1;
                        ctrl.aluSrc = 1'b1;
                        aluOp = aluOr;
                    end
                    fnJpr: ctrl.isJumpReg = 1'b1;
                    fnHlt: begin
                        ctrl.isHalt = 1'b1;
                        useRs = 1'b0;
                    end
                    default: useRs = 1'b0;
                endcase
            end
            opBne, opBeq: begin
                ctrl.isBranch = 1'b1;
                ctrl.branchOnEqual = (instr.iForm.opcode == opBeq);
                useRt = 1'b1;
            end
            opAdi: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc = 1'b1;
            end
            opOri: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc = 1'b1;
                aluOp = aluOr;
            end
            opLhi: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc = 1'b1;
                ctrl.isLink = 1'b1;
                useRs = 1'b0;
            end
            opLwd: begin
                ctrl.regWrite = 1'b1;
                ctrl.memToReg = 1'b1;
                ctrl.memRead = 1'b1;
                ctrl.aluSrc = 1'b1;
            end
            opSwd: begin
                ctrl.memWrite = 1'b1;
                ctrl.aluSrc = 1'b1;
                useRt = 1'b1;
            end
            opJal: begin
                ctrl.regWrite = 1'b1;
                ctrl.isLink = 1'b1;
                useRs = 1'b0;
            end
            // JMP and unknown opcodes read nothing
            default: useRs = 1'b0;
        endcase
    end

endmodule

// File: source/cpuCore.sv
`timescale 1ns/1ps

module cpuCore import cpuPkg::*; (
    input  logic                Clk,
    input  logic                rst,
    input  logic [wordSize-1:0] instData,
    input  logic [wordSize-1:0] dataIn,
    output logic                instRead,
    output logic [wordSize-1:0] instAddr,
    output logic                dataRead,
    output logic                dataWrite,
    output logic [wordSize-1:0] dataAddr,
    output logic [wordSize-1:0] dataOut,
    output logic [wordSize-1:0] outputPort,
    output logic                outputValid,
    output logic [wordSize-1:0] numInst,
    output logic                isHalted
);

    ifIdBundle           ifId;
    idExBundle           idEx;
    exMemBundle          exMem;
    memWbBundle          memWb;
    logic                stall;
    logic                flush;
    logic                exRedirect;
    logic [wordSize-1:0] exTarget;
    logic                idJump;
    logic [wordSize-1:0] idTarget;
    logic                haltSeen;
    logic [1:0]          rs;
    logic [1:0]          rt;
    logic                useRs;
    logic                useRt;
    logic [1:0]          fwdA;
    logic [1:0]          fwdB;
    logic                wbWrite;
    logic [1:0]          wbDest;
    logic [wordSize-1:0] wbData;

    fetchStage fetch (
        .Clk(Clk),
        .rst(rst),
        .stall(stall),
        .exRedirect(exRedirect),
        .exTarget(exTarget),
        .idJump(idJump),
        .idTarget(idTarget),
        .haltSeen(haltSeen),
        .instData(instData),
        .instRead(instRead),
        .instAddr(instAddr),
        .ifId(ifId)
    );

    decodeStage decode (
        .Clk(Clk),
        .rst(rst),
        .ifId(ifId),
        .stall(stall),
        .flush(flush),
        .wbWrite(wbWrite),
        .wbDest(wbDest),
        .wbData(wbData),
        .idEx(idEx),
        .idJump(idJump),
        .idTarget(idTarget),
        .haltSeen(haltSeen),
        .rs(rs),
        .rt(rt),
        .useRs(useRs),
        .useRt(useRt)
    );

    hazardUnit hazard (
        .Clk(Clk),
        .rst(rst),
        .rs(rs),
        .rt(rt),
        .useRs(useRs),
        .useRt(useRt),
        .idEx(idEx),
        .exMem(exMem),
        .memWb(memWb),
        .stall(stall),
        .fwdA(fwdA),
        .fwdB(fwdB)
    );

    executeStage execute (
        .Clk(Clk),
        .rst(rst),
        .idEx(idEx),
        .fwdA(fwdA),
        .fwdB(fwdB),
        .exMemResult(exMem.aluResult),
        .wbData(wbData),
        .exMem(exMem),
        .exRedirect(exRedirect),
        .exTarget(exTarget),
        .flush(flush)
    );

    memWriteback memStage (
        .Clk(Clk),
        .rst(rst),
        .exMem(exMem),
        .dataIn(dataIn),
        .dataRead(dataRead),
        .dataWrite(dataWrite),
        .dataAddr(dataAddr),
        .dataOut(dataOut),
        .memWb(memWb),
        .wbWrite(wbWrite),
        .wbDest(wbDest),
        .wbData(wbData),
        .outputPort(outputPort),
        .outputValid(outputValid),
        .numInst(numInst),
        .isHalted(isHalted)
    );

endmodule

// File: source/cpuPkg.sv
package cpuPkg;

    localparam int wordSize = 16;

    // Opcodes
    localparam logic [3:0] opBne   = 4'd0;
    localparam logic [3:0] opBeq   = 4'd1;
    localparam logic [3:0] opAdi   = 4'd4;
    localparam logic [3:0] opOri   = 4'd5;
    localparam logic [3:0] opLhi   = 4'd6;
    localparam logic [3:0] opLwd   = 4'd7;
    localparam logic [3:0] opSwd   = 4'd8;
    localparam logic [3:0] opJmp   = 4'd9;
    localparam logic [3:0] opJal   = 4'd10;
    localparam logic [3:0] opRtype = 4'd15;

    // R-type function codes
    localparam logic [5:0] fnAdd = 6'd0;
    localparam logic [5:0] fnSub = 6'd1;
    localparam logic [5:0] fnAnd = 6'd2;
    localparam logic [5:0] fnOrr = 6'd3;
    localparam logic [5:0] fnJpr = 6'd25;
    localparam logic [5:0] fnWwd = 6'd28;
    localparam logic [5:0] fnHlt = 6'd29;

    localparam logic [1:0] linkReg = 2'd2;

    // Low func bits of ADD..ORR line up with these
    localparam logic [1:0] aluAdd = 2'd0;
    localparam logic [1:0] aluSub = 2'd1;
    localparam logic [1:0] aluAnd = 2'd2;
    localparam logic [1:0] aluOr  = 2'd3;

    typedef union packed {
        struct packed {
            logic [3:0] opcode;
            logic [1:0] rs;
            logic [1:0] rt;
            logic [1:0] rd;
            logic [5:0] func;
        } rForm;
        struct packed {
            logic [3:0] opcode;
            logic [1:0] rs;
            logic [1:0] rt;
            logic [7:0] imm8;
        } iForm;
        struct packed {
            logic [3:0]  opcode;
            logic [11:0] target12;
        } jForm;
    } instrWord;

    typedef struct packed {
        logic regWrite;
        logic memToReg;
        logic memWrite;
        logic memRead;
        logic isBranch;
        logic branchOnEqual;
        logic aluSrc;
        logic isJumpReg;
        // Result skips the ALU: pc+1 for JAL, imm for LHI
        logic isLink;
        logic isWwd;
        logic isHalt;
    } ctrlBundle;

    typedef struct packed {
        logic                valid;
        logic [wordSize-1:0] pc;
        instrWord            instr;
    } ifIdBundle;

    typedef struct packed {
        logic                valid;
        ctrlBundle           ctrl;
        logic [1:0]          aluOp;
        logic [wordSize-1:0] pc;
        logic [wordSize-1:0] rsData;
        logic [wordSize-1:0] rtData;
        logic [1:0]          rs;
        logic [1:0]          rt;
        logic [1:0]          dest;
        logic [wordSize-1:0] imm;
    } idExBundle;

    typedef struct packed {
        logic                valid;
        ctrlBundle           ctrl;
        logic [wordSize-1:0] aluResult;
        logic [wordSize-1:0] storeData;
        logic [1:0]          dest;
    } exMemBundle;

    typedef struct packed {
        logic                valid;
        ctrlBundle           ctrl;
        logic [wordSize-1:0] result;
        logic [1:0]          dest;
    } memWbBundle;

endpackage

// File: source/decodeStage.sv
`timescale 1ns/1ps

module decodeStage import cpuPkg::*; (
    input  logic                Clk,
    input  logic                rst,
    input  ifIdBundle           ifId,
    input  logic                stall,
    input  logic                flush,
    input  logic                wbWrite,
    input  logic [1:0]          wbDest,
    input  logic [wordSize-1:0] wbData,
    output idExBundle           idEx,
    output logic                idJump,
    output logic [wordSize-1:0] idTarget,
    output logic                haltSeen,
    output logic [1:0]          rs,
    output logic [1:0]          rt,
    output logic                useRs,
    output logic                useRt
);

    ctrlBundle           ctrl;
    logic [1:0]          aluOp;
    logic                decRs;
    logic                decRt;
    logic [wordSize-1:0] rsData;
    logic [wordSize-1:0] rtData;
    logic [wordSize-1:0] imm;
    logic [1:0]          dest;
    logic [3:0]          opcode;
    logic [7:0]          imm8;

    controlDecoder decoder (
        .instr(ifId.instr),
        .ctrl(ctrl),
        .aluOp(aluOp),
        .useRs(decRs),
        .useRt(decRt)
    );

    registerFile regs (
        .Clk(Clk),
        .rst(rst),
        .rs(rs),
        .rt(rt),
        .wbWrite(wbWrite),
        .wbDest(wbDest),
        .wbData(wbData),
        .rsData(rsData),
        .rtData(rtData)
    );

    assign opcode = ifId.instr.iForm.opcode;
    assign imm8 = ifId.instr.iForm.imm8;
    assign rs = ifId.instr.iForm.rs;
    assign rt = ifId.instr.iForm.rt;
    assign useRs = ifId.valid && decRs;
    assign useRt = ifId.valid && decRt;

    assign idJump = ifId.valid && (opcode == opJmp || opcode == opJal);
    assign idTarget = {ifId.pc[wordSize-1:12], ifId.instr.jForm.target12};
    // A HLT behind a taken branch must not stop fetch
    assign haltSeen = ifId.valid && ctrl.isHalt && !flush;

    always_comb begin
        case (opcode)
            opAdi, opLwd, opSwd, opBne, opBeq: imm = {{8{imm8[7]}}, imm8};
            opOri: imm = {8'h00, imm8};
            opLhi: imm = {imm8, 8'h00};
            default: imm = '0;
        endcase
    end

    always_comb begin
        if (opcode == opRtype) begin
            dest = ifId.instr.rForm.rd;
        end else if (opcode == opJal) begin
            dest = linkReg;
        end else begin
            dest = rt;
        end
    end

    always_ff @(posedge Clk) begin
        idEx.aluOp <= aluOp;
        idEx.pc <= ifId.pc;
        idEx.rsData <= rsData;
        idEx.rtData <= rtData;
        idEx.rs <= rs;
        idEx.rt <= rt;
        idEx.dest <= dest;
        idEx.imm <= imm;
        if (rst || stall || flush) begin
            idEx.valid <= 1'b0;
            idEx.ctrl <= '0;
        end else begin
            idEx.valid <= ifId.valid;
            idEx.ctrl <= ifId.valid ? ctrl : '0;
        end
    end

endmodule

// File: source/executeStage.sv
`timescale 1ns/1ps

module executeStage import cpuPkg::*; (
    input  logic                Clk,
    input  logic                rst,
    input  idExBundle           idEx,
    input  logic [1:0]          fwdA,
    input  logic [1:0]          fwdB,
    input  logic [wordSize-1:0] exMemResult,
    input  logic [wordSize-1:0] wbData,
    output exMemBundle          exMem,
    output logic                exRedirect,
    output logic [wordSize-1:0] exTarget,
    output logic                flush
);

    logic [wordSize-1:0] opA;
    logic [wordSize-1:0] fwdRt;
    logic [wordSize-1:0] opB;
    logic [wordSize-1:0] aluOut;
    logic [wordSize-1:0] pcNext;
    logic                taken;

    function automatic logic [wordSize-1:0] pickOperand(
        input logic [1:0]          sel,
        input logic [wordSize-1:0] regValue
    );
        case (sel)
            2'd1: return exMemResult;
            2'd2: return wbData;
            default: return regValue;
        endcase
    endfunction

    assign opA = pickOperand(fwdA, idEx.rsData);
    assign fwdRt = pickOperand(fwdB, idEx.rtData);
    assign opB = idEx.ctrl.aluSrc ? idEx.imm : fwdRt;

    always_comb begin
        case (idEx.aluOp)
            aluAdd: aluOut = opA + opB;
            aluSub: aluOut = opA - opB;
            aluAnd: aluOut = opA & opB;
            default: aluOut = opA | opB;
        endcase
    end

    assign pcNext = idEx.pc + 1'b1;

    // BEQ takes on equal, BNE on not equal
    assign taken = idEx.ctrl.isBranch && ((opA == fwdRt) == idEx.ctrl.branchOnEqual);
    assign exRedirect = idEx.valid && (taken || idEx.ctrl.isJumpReg);
    assign exTarget = idEx.ctrl.isJumpReg ? opA : pcNext + idEx.imm;
    assign flush = exRedirect;

    always_ff @(posedge Clk) begin
        if (idEx.ctrl.isLink) begin
            exMem.aluResult <= idEx.ctrl.aluSrc ? idEx.imm : pcNext;
        end else begin
            exMem.aluResult <= aluOut;
        end
        exMem.storeData <= fwdRt;
        exMem.dest <= idEx.dest;
        if (rst) begin
            exMem.valid <= 1'b0;
            exMem.ctrl <= '0;
        end else begin
            exMem.valid <= idEx.valid;
            exMem.ctrl <= idEx.ctrl;
        end
    end

endmodule

// File: source/fetchStage.sv
`timescale 1ns/1ps

module fetchStage import cpuPkg::*; (
    input  logic                Clk,
    input  logic                rst,
    input  logic                stall,
    input  logic                exRedirect,
    input  logic [wordSize-1:0] exTarget,
    input  logic                idJump,
    input  logic [wordSize-1:0] idTarget,
    input  logic                haltSeen,
    input  logic [wordSize-1:0] instData,
    output logic                instRead,
    output logic [wordSize-1:0] instAddr,
    output ifIdBundle           ifId
);

    logic [wordSize-1:0] pc;
    logic [wordSize-1:0] nextPc;
    logic                halted;

    assign instRead = !(halted || haltSeen);
    assign instAddr = pc;

    always_comb begin
        if (exRedirect) begin
            nextPc = exTarget;
        end else if (idJump) begin
            nextPc = idTarget;
        end else if (stall || !instRead) begin
            nextPc = pc;
        end else begin
            nextPc = pc + 1'b1;
        end
    end

    always_ff @(posedge Clk) begin
        if (rst) begin
            pc <= '0;
            halted <= 1'b0;
            ifId.valid <= 1'b0;
        end else begin
            pc <= nextPc;
            if (haltSeen) begin
                halted <= 1'b1;
            end
            // Drop the word fetched behind a redirect, a jump or HLT
            if (exRedirect || idJump || !instRead) begin
                ifId.valid <= 1'b0;
            end else if (!stall) begin
                ifId.valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge Clk) begin
        if (!stall) begin
            ifId.pc <= pc;
            ifId.instr <= instData;
        end
    end

    // Fetch stays stopped and pc frozen once HLT is in decode
    assert property (@(posedge Clk) disable iff (rst)
        (haltSeen || !instRead) |=> !instRead && $stable(pc))
        else $error("fetch resumed or pc moved after halt");

endmodule

// File: source/hazardUnit.sv
`timescale 1ns/1ps

module hazardUnit import cpuPkg::*; (
    input  logic       Clk,
    input  logic       rst,
    input  logic [1:0] rs,
    input  logic [1:0] rt,
    input  logic       useRs,
    input  logic       useRt,
    input  idExBundle  idEx,
    input  exMemBundle exMem,
    input  memWbBundle memWb,
    output logic       stall,
    output logic [1:0] fwdA,
    output logic [1:0] fwdB
);

    // EX/MEM holds the younger producer, so it wins
    function automatic logic [1:0] fwdSel(input logic [1:0] src);
        if (exMem.valid && exMem.ctrl.regWrite && exMem.dest == src) begin
            return 2'd1;
        end else if (memWb.valid && memWb.ctrl.regWrite && memWb.dest == src) begin
            return 2'd2;
        end
        return 2'd0;
    endfunction

    assign stall = idEx.valid && idEx.ctrl.memRead
        && ((useRs && rs == idEx.dest) || (useRt && rt == idEx.dest));

    assign fwdA = fwdSel(idEx.rs);
    assign fwdB = fwdSel(idEx.rt);

    // The bubble behind a load clears the hazard
    assert property (@(posedge Clk) disable iff (rst) stall |=> !stall)
        else $error("load-use stall held for two cycles");

endmodule

// File: source/memWriteback.sv
`timescale 1ns/1ps

module memWriteback import cpuPkg::*; (
    input  logic                Clk,
    input  logic                rst,
    input  exMemBundle          exMem,
    input  logic [wordSize-1:0] dataIn,
    output logic                dataRead,
    output logic                dataWrite,
    output logic [wordSize-1:0] dataAddr,
    output logic [wordSize-1:0] dataOut,
    output memWbBundle          memWb,
    output logic                wbWrite,
    output logic [1:0]          wbDest,
    output logic [wordSize-1:0] wbData,
    output logic [wordSize-1:0] outputPort,
    output logic                outputValid,
    output logic [wordSize-1:0] numInst,
    output logic                isHalted
);

    assign dataRead = exMem.valid && exMem.ctrl.memRead;
    assign dataWrite = exMem.valid && exMem.ctrl.memWrite;
    assign dataAddr = exMem.aluResult;
    assign dataOut = exMem.storeData;

    always_ff @(posedge Clk) begin
        memWb.result <= exMem.ctrl.memToReg ? dataIn : exMem.aluResult;
        memWb.dest <= exMem.dest;
        if (rst) begin
            memWb.valid <= 1'b0;
            memWb.ctrl <= '0;
        end else begin
            memWb.valid <= exMem.valid;
            memWb.ctrl <= exMem.ctrl;
        end
    end

    assign wbWrite = memWb.valid && memWb.ctrl.regWrite;
    assign wbDest = memWb.dest;
    assign wbData = memWb.result;

    // Retirement
    always_ff @(posedge Clk) begin
        if (rst) begin
            numInst <= '0;
            outputPort <= '0;
            outputValid <= 1'b0;
            isHalted <= 1'b0;
        end else begin
            outputValid <= memWb.valid && memWb.ctrl.isWwd;
            if (memWb.valid) begin
                numInst <= numInst + 1'b1;
                if (memWb.ctrl.isWwd) begin
                    outputPort <= memWb.result;
                end
                if (memWb.ctrl.isHalt) begin
                    isHalted <= 1'b1;
                end
            end
        end
    end

    assert property (@(posedge Clk) disable iff (rst) !(dataRead && dataWrite))
        else $error("data memory read and write in the same cycle");

endmodule

// File: source/registerFile.sv
`timescale 1ns/1ps

module registerFile import cpuPkg::*; (
    input  logic                Clk,
    input  logic                rst,
    input  logic [1:0]          rs,
    input  logic [1:0]          rt,
    input  logic                wbWrite,
    input  logic [1:0]          wbDest,
    input  logic [wordSize-1:0] wbData,
    output logic [wordSize-1:0] rsData,
    output logic [wordSize-1:0] rtData
);

    logic [wordSize-1:0] regs [4];

    always_ff @(posedge Clk) begin
        if (rst) begin
            for (int i = 0; i < 4; i++) begin
                regs[i] <= '0;
            end
        end else if (wbWrite) begin
            regs[wbDest] <= wbData;
        end
    end

    // Same-cycle write is visible to the reader
    assign rsData = (wbWrite && wbDest == rs) ? wbData : regs[rs];
    assign rtData = (wbWrite && wbDest == rt) ? wbData : regs[rt];

endmodule

// File: verification/clockGen.sv
`timescale 1ns/1ps

module clockGen (
    output logic Clk,
    output logic rst
);

    // 40 ns period
    initial begin
        Clk = 1'b0;
        forever #20 Clk = ~Clk;
    end

    // Held for 5 rising edges, released on a falling edge
    initial begin
        rst = 1'b1;
        repeat (5) @(posedge Clk);
        @(negedge Clk);
        rst = 1'b0;
    end

endmodule

// File: verification/cpuModel.svh
// Instruction encoders
function automatic logic [15:0] rTypeWord(input logic [5:0] func, input logic [1:0] rs,
                                          input logic [1:0] rt, input logic [1:0] rd);
    return {opRtype, rs, rt, rd, func};
endfunction

function automatic logic [15:0] immWord(input logic [3:0] op, input logic [1:0] rs,
                                        input logic [1:0] rt, input logic [7:0] imm8);
    return {op, rs, rt, imm8};
endfunction

function automatic logic [15:0] jumpWord(input logic [3:0] op, input logic [11:0] target);
    return {op, target};
endfunction

task automatic fillDataMemory();
    for (int i = 0; i < 256; i++) begin
        dataMem[i] = 16'($random(seed));
    end
endtask

task automatic buildProgram();
    logic [7:0] imm [6];
    // Unused words jump to themselves
    for (int i = 0; i < 256; i++) begin
        instMem[i] = jumpWord(opJmp, 12'(i));
    end
    for (int i = 0; i < 6; i++) begin
        imm[i] = 8'($random(seed));
    end
    // Forwarding chains
    instMem[0] = immWord(opAdi, 2'd0, 2'd1, imm[0]);
    instMem[1] = immWord(opAdi, 2'd1, 2'd2, imm[1]);
    instMem[2] = rTypeWord(fnAdd, 2'd1, 2'd2, 2'd3);
    instMem[3] = rTypeWord(fnWwd, 2'd3, 2'd0, 2'd0);
    instMem[4] = rTypeWord(fnSub, 2'd3, 2'd1, 2'd0);
    instMem[5] = rTypeWord(fnAnd, 2'd0, 2'd3, 2'd1);
    instMem[6] = rTypeWord(fnOrr, 2'd1, 2'd0, 2'd2);
    instMem[7] = rTypeWord(fnWwd, 2'd2, 2'd0, 2'd0);
    instMem[8] = immWord(opOri, 2'd0, 2'd3, imm[2]);
    instMem[9] = immWord(opLhi, 2'd0, 2'd1, imm[3]);
    instMem[10] = rTypeWord(fnOrr, 2'd1, 2'd3, 2'd1);
    instMem[11] = rTypeWord(fnWwd, 2'd1, 2'd0, 2'd0);
    // Store then load back, load-use on both source kinds
    instMem[12] = immWord(opSwd, 2'd3, 2'd1, imm[4]);
    instMem[13] = immWord(opLwd, 2'd3, 2'd2, imm[4]);
    instMem[14] = rTypeWord(fnAdd, 2'd2, 2'd2, 2'd0);
    instMem[15] = rTypeWord(fnWwd, 2'd0, 2'd0, 2'd0);
    instMem[16] = immWord(opLwd, 2'd0, 2'd1, imm[5]);
    instMem[17] = immWord(opSwd, 2'd0, 2'd1, imm[1]);
    instMem[18] = rTypeWord(fnWwd, 2'd1, 2'd0, 2'd0);
    // Branches, taken and not taken
    instMem[19] = immWord(opBeq, 2'd1, 2'd1, 8'd2);
    instMem[20] = rTypeWord(fnWwd, 2'd3, 2'd0, 2'd0);
    instMem[21] = immWord(opSwd, 2'd0, 2'd3, 8'd0);
    instMem[22] = immWord(opBne, 2'd1, 2'd1, 8'd5);
    instMem[23] = immWord(opAdi, 2'd1, 2'd3, 8'd1);
    instMem[24] = immWord(opBne, 2'd3, 2'd1, 8'd1);
    instMem[25] = rTypeWord(fnWwd, 2'd3, 2'd0, 2'd0);
    instMem[26] = immWord(opBeq, 2'd3, 2'd1, 8'd3);
    // Jumps and a call through r2
    instMem[27] = jumpWord(opJmp, 12'd29);
    instMem[28] = rTypeWord(fnWwd, 2'd0, 2'd0, 2'd0);
    instMem[29] = jumpWord(opJal, 12'd40);
    instMem[30] = rTypeWord(fnWwd, 2'd2, 2'd0, 2'd0);
    instMem[31] = rTypeWord(fnWwd, 2'd1, 2'd0, 2'd0);
    instMem[32] = rTypeWord(fnHlt, 2'd0, 2'd0, 2'd0);
    instMem[40] = immWord(opAdi, 2'd1, 2'd1, imm[2]);
    instMem[41] = immWord(opSwd, 2'd0, 2'd2, imm[3]);
    instMem[42] = rTypeWord(fnJpr, 2'd2, 2'd0, 2'd0);
    instMem[43] = rTypeWord(fnWwd, 2'd1, 2'd0, 2'd0);
    instMem[44] = rTypeWord(fnHlt, 2'd0, 2'd0, 2'd0);
endtask

// Instruction-level reference, returns the retired count
function automatic int runReference();
    logic [15:0] regs [4];
    logic [15:0] mem [256];
    logic [15:0] pc;
    logic [15:0] thisPc;
    logic [15:0] word;
    logic [15:0] sImm;
    logic [15:0] addr;
    logic [1:0]  rs;
    logic [1:0]  rt;
    logic [1:0]  rd;
    int          count;
    bit          done;
    regs = '{default: '0};
    mem = dataMem;
    pc = '0;
    count = 0;
    done = 1'b0;
    while (!done && count < 1000) begin
        thisPc = pc;
        word = instMem[pc[7:0]];
        rs = word[11:10];
        rt = word[9:8];
        rd = word[7:6];
        sImm = {{8{word[7]}}, word[7:0]};
        pc = pc + 16'd1;
        count++;
        case (word[15:12])
            opRtype: begin
                case (word[5:0])
                    fnAdd: regs[rd] = regs[rs] + regs[rt];
                    fnSub: regs[rd] = regs[rs] - regs[rt];
                    fnAnd: regs[rd] = regs[rs] & regs[rt];
                    fnOrr: regs[rd] = regs[rs] | regs[rt];
                    fnWwd: expOutputs.push_back(regs[rs]);
                    fnJpr: pc = regs[rs];
                    fnHlt: done = 1'b1;
                    default: ;
                endcase
            end
            opBne: pc = (regs[rs] != regs[rt]) ? pc + sImm : pc;
            opBeq: pc = (regs[rs] == regs[rt]) ? pc + sImm : pc;
            opAdi: regs[rt] = regs[rs] + sImm;
            opOri: regs[rt] = regs[rs] | {8'h00, word[7:0]};
            opLhi: regs[rt] = {word[7:0], 8'h00};
            opLwd: begin
                addr = regs[rs] + sImm;
                regs[rt] = mem[addr[7:0]];
                expLoads.push_back(addr);
            end
            opSwd: begin
                addr = regs[rs] + sImm;
                mem[addr[7:0]] = regs[rt];
                expStores.push_back(storeEvent'({addr, regs[rt]}));
            end
            opJmp: pc = {thisPc[15:12], word[11:0]};
            opJal: begin
                regs[linkReg] = pc;
                pc = {thisPc[15:12], word[11:0]};
            end
            default: ;
        endcase
    end
    return count;
endfunction

// File: verification/cpuCoreTb.sv
`timescale 1ns/1ps

module cpuCoreTb import cpuPkg::*; ();

    typedef struct packed {
        logic [wordSize-1:0] addr;
        logic [wordSize-1:0] data;
    } storeEvent;

    logic                Clk;
    logic                rst;
    logic [wordSize-1:0] instData;
    logic [wordSize-1:0] dataIn;
    logic                instRead;
    logic [wordSize-1:0] instAddr;
    logic                dataRead;
    logic                dataWrite;
    logic [wordSize-1:0] dataAddr;
    logic [wordSize-1:0] dataOut;
    logic [wordSize-1:0] outputPort;
    logic                outputValid;
    logic [wordSize-1:0] numInst;
    logic                isHalted;

    logic [wordSize-1:0] instMem [256];
    logic [wordSize-1:0] dataMem [256];
    int                  seed = 32'hab129878;
    logic [wordSize-1:0] expOutputs [$];
    logic [wordSize-1:0] expLoads [$];
    storeEvent           expStores [$];
    int                  expRetired;
    int                  outIdx = 0;
    int                  loadIdx = 0;
    int                  storeIdx = 0;
    int                  mismatches = 0;
    int                  failures = 0;

    `include "cpuModel.svh"

    clockGen clocks (
        .Clk(Clk),
        .rst(rst)
    );

    cpuCore UUT (
        .Clk(Clk),
        .rst(rst),
        .instData(instData),
        .dataIn(dataIn),
        .instRead(instRead),
        .instAddr(instAddr),
        .dataRead(dataRead),
        .dataWrite(dataWrite),
        .dataAddr(dataAddr),
        .dataOut(dataOut),
        .outputPort(outputPort),
        .outputValid(outputValid),
        .numInst(numInst),
        .isHalted(isHalted)
    );

    // Asynchronous read, store lands on the rising edge
    assign instData = instMem[instAddr[7:0]];
    assign dataIn = dataMem[dataAddr[7:0]];

    always @(posedge Clk) begin
        if (dataWrite === 1'b1) begin
            dataMem[dataAddr[7:0]] <= dataOut;
        end
    end

    task automatic compareWord(input string name, input logic [15:0] expected,
                               input logic [15:0] actual);
        if (actual !== expected) begin
            $display("Mismatch at %0t: %s expected %h got %h", $time, name, expected, actual);
            mismatches++;
        end
    endtask

    // Output, load and store events, in program order
    always @(posedge Clk) begin
        if (rst === 1'b0) begin
            if (isHalted === 1'b1 && (outputValid !== 1'b0 || dataWrite !== 1'b0)) begin
                $display("Output or store seen after halt at %0t", $time);
                failures++;
            end
            if (outputValid === 1'b1) begin
                if (outIdx >= expOutputs.size()) begin
                    $display("Unexpected output %h at %0t", outputPort, $time);
                    failures++;
                end else begin
                    compareWord("outputPort", expOutputs[outIdx], outputPort);
                    outIdx++;
                end
            end
            if (dataRead === 1'b1) begin
                if (loadIdx >= expLoads.size()) begin
                    $display("Unexpected load from %h at %0t", dataAddr, $time);
                    failures++;
                end else begin
                    compareWord("dataAddr", expLoads[loadIdx], dataAddr);
                    loadIdx++;
                end
            end
            if (dataWrite === 1'b1) begin
                if (storeIdx >= expStores.size()) begin
                    $display("Unexpected store to %h at %0t", dataAddr, $time);
                    failures++;
                end else begin
                    compareWord("dataAddr", expStores[storeIdx].addr, dataAddr);
                    compareWord("dataOut", expStores[storeIdx].data, dataOut);
                    storeIdx++;
                end
            end
        end
    end

    task automatic syncToReset(output bit released);
        int cycles;
        cycles = 0;
        while (rst !== 1'b0 && cycles < 20) begin
            @(posedge Clk);
            cycles++;
        end
        released = (rst === 1'b0);
    endtask

    task automatic verifyResetState();
        compareWord("isHalted", 16'd0, 16'(isHalted));
        compareWord("outputValid", 16'd0, 16'(outputValid));
        compareWord("dataRead", 16'd0, 16'(dataRead));
        compareWord("dataWrite", 16'd0, 16'(dataWrite));
        compareWord("numInst", 16'd0, numInst);
        compareWord("instRead", 16'd1, 16'(instRead));
    endtask

    task automatic waitForHalt(output bit reached);
        int cycles;
        cycles = 0;
        while (isHalted !== 1'b1 && cycles < 2000) begin
            @(posedge Clk);
            cycles++;
        end
        reached = (isHalted === 1'b1);
    endtask

    task automatic watchIdle();
        repeat (20) begin
            @(negedge Clk);
            if (instRead !== 1'b0) begin
                $display("instRead went high again at %0t after halt", $time);
                failures++;
            end
        end
    endtask

    initial begin
        bit released;
        bit halted;
        buildProgram();
        fillDataMemory();
        expRetired = runReference();
        syncToReset(released);
        if (!released) begin
            $display("Reset was never released");
            failures++;
        end else begin
            @(negedge Clk);
            verifyResetState();
            waitForHalt(halted);
            if (!halted) begin
                $display("Timeout: isHalted did not rise within 2000 cycles");
                failures++;
            end else begin
                @(negedge Clk);
                compareWord("numInst", 16'(expRetired), numInst);
                watchIdle();
                if (outIdx != expOutputs.size()) begin
                    $display("Only %0d of %0d outputs seen", outIdx, expOutputs.size());
                    failures++;
                end
                if (loadIdx != expLoads.size()) begin
                    $display("Only %0d of %0d loads seen", loadIdx, expLoads.size());
                    failures++;
                end
                if (storeIdx != expStores.size()) begin
                    $display("Only %0d of %0d stores seen", storeIdx, expStores.size());
                    failures++;
                end
            end
        end
        $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule
